// ==== frame_uart.f ====
+incdir+include
verilog/frame_uart_pkg.sv
verilog/frame_ctrl.sv
verilog/frame_store.sv
verilog/pixel_serializer.sv
verilog/uart_tx.sv
verilog/frame_uart_top.sv
test/frame_uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the frame_uart testbench with Verilator.
# Exit status is zero only when the simulation log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
sim_bin=frame_uart_sim

verilator --binary --timing \
  -f frame_uart.f \
  --top-module frame_uart_tb \
  --Mdir obj_dir \
  -o "$sim_bin" > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $build_log"
  exit 1
fi

./obj_dir/"$sim_bin" > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $sim_log"
  exit 1
fi

if grep -qx "All checks passed" "$sim_log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see $sim_log"
  exit 1
fi

// ==== test/frame_uart_tb.sv ====
`timescale 1ns/1ns

`include "frame_uart_cfg.svh"

module frame_uart_tb;

  localparam int n_rows   = 3;
  localparam int n_bytes  = 3 * `FRAME_PIXELS;
  localparam int bit_clks = `CLKS_PER_BIT;

  logic                clk;
  logic                uart_reset;
  logic                pixel_strobe;
  logic [`PIXEL_W-1:0] pixel_data;
  logic                frame_start;
  logic                store;
  logic                send;
  logic                txd;
  logic                busy;
  logic                frame_ready;

  // stimulus table, one frame per row
  frame_uart_pkg::pixel_t     pix_tab [n_rows][`FRAME_PIXELS];
  frame_uart_pkg::uart_byte_t exp_tab [n_rows][n_bytes];
  logic                       resend_tab [n_rows];

  int seed;
  int mismatches;
  int timeouts;

  frame_uart_top i_dut (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .pixel_strobe (pixel_strobe),
    .pixel_data   (pixel_data),
    .frame_start  (frame_start),
    .store        (store),
    .send         (send),
    .txd          (txd),
    .busy         (busy),
    .frame_ready  (frame_ready)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_byte(
    input string                      name,
    input frame_uart_pkg::uart_byte_t exp,
    input frame_uart_pkg::uart_byte_t got
  );
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic pulse_store();
    next_cycle();
    store = 1'b1;
    next_cycle();
    store = 1'b0;
  endtask

  task automatic pulse_send();
    next_cycle();
    send = 1'b1;
    next_cycle();
    send = 1'b0;
  endtask

  task automatic pulse_frame_start();
    next_cycle();
    frame_start = 1'b1;
    next_cycle();
    frame_start = 1'b0;
  endtask

  // one pixel, then a random idle gap of 0..3 cycles
  task automatic send_pixel(input frame_uart_pkg::pixel_t pix);
    int tmp;
    next_cycle();
    pixel_strobe = 1'b1;
    pixel_data   = pix;
    next_cycle();
    pixel_strobe = 1'b0;
    tmp = $random(seed);
    repeat (tmp[1:0]) next_cycle();
  endtask

  // fixed rows written out, random row from the field rule
  task automatic build_table();
    frame_uart_pkg::uart_byte_t ones_exp [3];
    frame_uart_pkg::uart_byte_t aa_exp [3];
    frame_uart_pkg::uart_byte_t x55_exp [3];
    frame_uart_pkg::pixel_t     pix;
    int tmp;
    // green, blue, red
    ones_exp = '{8'hE0, 8'hC0, 8'hE0};
    aa_exp   = '{8'h40, 8'h80, 8'hA0};
    x55_exp  = '{8'hA0, 8'h40, 8'h40};
    for (int i = 0; i < `FRAME_PIXELS; i++) begin
      pix_tab[0][i] = 8'hFF;
      pix_tab[1][i] = (i % 2 == 0) ? 8'hAA : 8'h55;
      tmp = $random(seed);
      pix = tmp[7:0];
      pix_tab[2][i] = pix;
      for (int c = 0; c < 3; c++) begin
        exp_tab[0][3*i+c] = ones_exp[c];
        exp_tab[1][3*i+c] = (i % 2 == 0) ? aa_exp[c] : x55_exp[c];
      end
      // each field moved to the top of the byte, rest masked off
      exp_tab[2][3*i]   = (pix << 3) & 8'hE0;
      exp_tab[2][3*i+1] = (pix << 6) & 8'hC0;
      exp_tab[2][3*i+2] = pix & 8'hE0;
    end
    resend_tab = '{1'b1, 1'b0, 1'b0};
  endtask

  ////////////////////////////////////////
  // UART receiver model
  ////////////////////////////////////////

  // samples on falling clock edges, bit slots aligned to the start edge
  task automatic receive_byte(
    output frame_uart_pkg::uart_byte_t b,
    output logic                       ok
  );
    int   waited;
    logic first;
    b      = '0;
    ok     = 1'b0;
    waited = 0;
    first  = 1'b1;
    @(negedge clk);
    while (txd !== 1'b0 && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (txd !== 1'b0) begin
      timeouts++;
      $display("Timeout at %0t ns: no start bit seen on txd", $time);
    end else begin
      for (int k = 0; k < 10; k++) begin
        for (int c = 0; c < bit_clks; c++) begin
          if (k != 0 || c != 0) begin
            @(negedge clk);
          end
          if (c == 0) begin
            first = txd;
          end else if (txd !== first) begin
            mismatches++;
            $display("txd changed level inside bit %0d at %0t ns", k, $time);
          end
          // mid-bit sample
          if (c == bit_clks / 2) begin
            if (k == 0) begin
              check_flag("txd start bit", 1'b0, txd);
            end else if (k == 9) begin
              check_flag("txd stop bit", 1'b1, txd);
              check_flag("busy", 1'b1, busy);
            end else begin
              b[k-1] = txd;
            end
          end
        end
      end
      ok = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // frame sequences
  ////////////////////////////////////////

  task automatic capture_frame(input int row);
    int n;
    pulse_store();
    check_flag("frame_ready", 1'b0, frame_ready);
    // armed but no frame start yet, must be dropped
    repeat (3) send_pixel(8'h3C);
    pulse_frame_start();
    for (int i = 0; i < `FRAME_PIXELS; i++) begin
      if (i == `FRAME_PIXELS - 1) begin
        check_flag("frame_ready", 1'b0, frame_ready);
      end
      send_pixel(pix_tab[row][i]);
    end
    n = 0;
    while (frame_ready !== 1'b1 && n < 10) begin
      next_cycle();
      n++;
    end
    if (frame_ready !== 1'b1) begin
      timeouts++;
      $display("Timeout at %0t ns: frame_ready never rose after capture", $time);
    end
  endtask

  task automatic send_and_check(input int row);
    frame_uart_pkg::uart_byte_t got;
    logic ok;
    int   n;
    pulse_send();
    check_flag("busy", 1'b1, busy);
    for (int i = 0; i < n_bytes; i++) begin
      receive_byte(got, ok);
      if (!ok) begin
        break;
      end
      check_byte($sformatf("byte %0d of row %0d", i, row), exp_tab[row][i], got);
    end
    n = 0;
    while (busy !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (busy !== 1'b0) begin
      timeouts++;
      $display("Timeout at %0t ns: busy never dropped after the last byte", $time);
    end
    check_flag("frame_ready", 1'b1, frame_ready);
    // no byte beyond the 48th
    repeat (2 * bit_clks) begin
      @(negedge clk);
      check_flag("txd idle", 1'b1, txd);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    seed         = 7;
    mismatches   = 0;
    timeouts     = 0;
    uart_reset   = 1'b1;
    pixel_strobe = 1'b0;
    pixel_data   = '0;
    frame_start  = 1'b0;
    store        = 1'b0;
    send         = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    #5;
    uart_reset = 1'b0;

    // state right after reset
    check_flag("txd", 1'b1, txd);
    check_flag("busy", 1'b0, busy);
    check_flag("frame_ready", 1'b0, frame_ready);

    // send with nothing captured is ignored
    pulse_send();
    repeat (100) begin
      @(negedge clk);
      check_flag("txd", 1'b1, txd);
      check_flag("busy", 1'b0, busy);
    end

    for (int r = 0; r < n_rows; r++) begin
      capture_frame(r);
      send_and_check(r);
      if (resend_tab[r]) begin
        send_and_check(r);
      end
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verilog/frame_uart_top.sv ====
`timescale 1ns/1ns

`include "frame_uart_cfg.svh"

module frame_uart_top (
  input  logic               clk,
  input  logic               uart_reset,
  input  logic               pixel_strobe,
  input  logic [`PIXEL_W-1:0] pixel_data,
  input  logic               frame_start,
  input  logic               store,
  input  logic               send,
  output logic               txd,
  output logic               busy,
  output logic               frame_ready
);

  // controller strobes
  logic capture_en;
  logic capture_done;
  logic send_start;
  logic send_done;

  // frame RAM read port
  frame_uart_pkg::frame_addr_t rd_addr;
  frame_uart_pkg::pixel_t      rd_data;

  // serializer to transmitter
  logic                       byte_strobe;
  frame_uart_pkg::uart_byte_t byte_data;
  logic                       tx_busy;

  ////////////////////////////////////////
  // phase control
  ////////////////////////////////////////

  frame_ctrl i_frame_ctrl (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .store        (store),
    .send         (send),
    .frame_start  (frame_start),
    .capture_done (capture_done),
    .send_done    (send_done),
    .capture_en   (capture_en),
    .send_start   (send_start),
    .busy         (busy),
    .frame_ready  (frame_ready)
  );

  ////////////////////////////////////////
  // frame buffer
  ////////////////////////////////////////

  frame_store i_frame_store (
    .clk          (clk),
    .uart_reset   (uart_reset),
    .capture_en   (capture_en),
    .pixel_strobe (pixel_strobe),
    .pixel_data   (pixel_data),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .capture_done (capture_done)
  );

  ////////////////////////////////////////
  // readout path to the PC
  ////////////////////////////////////////

  pixel_serializer i_pixel_serializer (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .send_start  (send_start),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .tx_busy     (tx_busy),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .send_done   (send_done)
  );

  uart_tx i_uart_tx (
    .clk         (clk),
    .uart_reset  (uart_reset),
    .byte_strobe (byte_strobe),
    .byte_data   (byte_data),
    .txd         (txd),
    .tx_busy     (tx_busy)
  );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ns

`include "frame_uart_cfg.svh"

module uart_tx (
  input  logic                       clk,
  input  logic                       uart_reset,
  input  logic                       byte_strobe,
  input  frame_uart_pkg::uart_byte_t byte_data,
  output logic                       txd,
  output logic                       tx_busy
);

  localparam int cnt_w = $clog2(`CLKS_PER_BIT);
  localparam int idx_w = $clog2(`UART_BYTE_W);
  localparam logic [cnt_w-1:0] last_clk = cnt_w'(`CLKS_PER_BIT - 1);
  localparam logic [idx_w-1:0] last_bit = idx_w'(`UART_BYTE_W - 1);

  frame_uart_pkg::uart_state_e state;
  frame_uart_pkg::uart_byte_t  shift_reg;
  logic [cnt_w-1:0] clk_cnt;
  logic [idx_w-1:0] bit_idx;
  logic bit_end;

  // last clock of the current bit time
  assign bit_end = (clk_cnt == last_clk);

  ////////////////////////////////////////
  // 8N1 sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state   <= frame_uart_pkg::uart_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      // divider runs in every phase but idle
      if (state != frame_uart_pkg::uart_idle) begin
        clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      end
      case (state)
        frame_uart_pkg::uart_idle: begin
          if (byte_strobe) begin
            state   <= frame_uart_pkg::uart_start;
            clk_cnt <= '0;
          end
        end
        frame_uart_pkg::uart_start: begin
          if (bit_end) begin
            state   <= frame_uart_pkg::uart_data;
            bit_idx <= '0;
          end
        end
        frame_uart_pkg::uart_data: begin
          // lsb first
          if (bit_end) begin
            if (bit_idx == last_bit) begin
              state <= frame_uart_pkg::uart_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: begin
          // stop bit, then free again
          if (bit_end) begin
            state <= frame_uart_pkg::uart_idle;
          end
        end
      endcase
    end
  end

  // data shifter
  always_ff @(posedge clk) begin
    if (state == frame_uart_pkg::uart_idle && byte_strobe) begin
      shift_reg <= byte_data;
    end else if (state == frame_uart_pkg::uart_data && bit_end) begin
      shift_reg <= shift_reg >> 1;
    end
  end

  // line idles high
  always_comb begin
    case (state)
      frame_uart_pkg::uart_start: txd = 1'b0;
      frame_uart_pkg::uart_data:  txd = shift_reg[0];
      default:                    txd = 1'b1;
    endcase
  end

  assign tx_busy = (state != frame_uart_pkg::uart_idle);

endmodule

// ==== verilog/pixel_serializer.sv ====
`timescale 1ns/1ns

`include "frame_uart_cfg.svh"

module pixel_serializer (
  input  logic                        clk,
  input  logic                        uart_reset,
  input  logic                        send_start,
  output frame_uart_pkg::frame_addr_t rd_addr,
  input  frame_uart_pkg::pixel_t      rd_data,
  input  logic                        tx_busy,
  output logic                        byte_strobe,
  output frame_uart_pkg::uart_byte_t  byte_data,
  output logic                        send_done
);

  localparam frame_uart_pkg::frame_addr_t last_addr =
    frame_uart_pkg::frame_addr_t'(`FRAME_PIXELS - 1);

  frame_uart_pkg::color_sel_e color;
  logic active;
  logic last_byte;
  logic rd_valid;
  logic issue;
  logic finish;

  // field left aligned, zeros below
  function automatic frame_uart_pkg::uart_byte_t format_byte(
    input frame_uart_pkg::pixel_t     pix,
    input frame_uart_pkg::color_sel_e sel
  );
    frame_uart_pkg::uart_byte_t b;
    b = '0;
    case (sel)
      frame_uart_pkg::color_green: b = {pix[4:2], {(`UART_BYTE_W - 3){1'b0}}};
      frame_uart_pkg::color_blue:  b = {pix[1:0], {(`UART_BYTE_W - 2){1'b0}}};
      frame_uart_pkg::color_red:   b = {pix[7:5], {(`UART_BYTE_W - 3){1'b0}}};
      default:                     b = '0;
    endcase
    return b;
  endfunction

  // next byte once read data is settled and the line is free
  // tx_busy only rises the cycle after the strobe, hence the strobe term
  assign issue  = active && rd_valid && !last_byte && !tx_busy && !byte_strobe;
  // last stop bit finished
  assign finish = active && last_byte && !tx_busy && !byte_strobe;

  ////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      active      <= 1'b0;
      last_byte   <= 1'b0;
      rd_valid    <= 1'b0;
      rd_addr     <= '0;
      color       <= frame_uart_pkg::color_green;
      byte_strobe <= 1'b0;
      send_done   <= 1'b0;
    end else begin
      byte_strobe <= issue;
      send_done   <= finish;
      // RAM output good one cycle after a stable address
      rd_valid    <= active;
      if (send_start) begin
        active    <= 1'b1;
        last_byte <= 1'b0;
        rd_valid  <= 1'b0;
        rd_addr   <= '0;
        color     <= frame_uart_pkg::color_green;
      end else if (finish) begin
        active    <= 1'b0;
        last_byte <= 1'b0;
      end else if (issue) begin
        case (color)
          frame_uart_pkg::color_green: color <= frame_uart_pkg::color_blue;
          frame_uart_pkg::color_blue:  color <= frame_uart_pkg::color_red;
          default: begin
            // red sent, move on to the next pixel
            color <= frame_uart_pkg::color_green;
            if (rd_addr == last_addr) begin
              last_byte <= 1'b1;
            end else begin
              rd_addr  <= rd_addr + 1'b1;
              rd_valid <= 1'b0;
            end
          end
        endcase
      end
    end
  end

  // byte payload, loaded with the strobe
  always_ff @(posedge clk) begin
    if (issue) begin
      byte_data <= format_byte(rd_data, color);
    end
  end

endmodule

// ==== verilog/frame_store.sv ====
`timescale 1ns/1ns

`include "frame_uart_cfg.svh"

module frame_store (
  input  logic                        clk,
  input  logic                        uart_reset,
  input  logic                        capture_en,
  input  logic                        pixel_strobe,
  input  frame_uart_pkg::pixel_t      pixel_data,
  input  frame_uart_pkg::frame_addr_t rd_addr,
  output frame_uart_pkg::pixel_t      rd_data,
  output logic                        capture_done
);

  localparam frame_uart_pkg::frame_addr_t last_addr =
    frame_uart_pkg::frame_addr_t'(`FRAME_PIXELS - 1);

  // frame RAM, one pixel per entry
  frame_uart_pkg::pixel_t mem [`FRAME_PIXELS];

  frame_uart_pkg::frame_addr_t wr_addr;
  logic wr_en;

  // only strobes inside the capture window count
  assign wr_en = capture_en && pixel_strobe;

  ////////////////////////////////////////
  // write pointer
  ////////////////////////////////////////

  // held at zero outside capture so each frame starts at 0
  always_ff @(posedge clk) begin
    if (uart_reset || !capture_en) begin
      wr_addr <= '0;
    end else if (pixel_strobe) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  ////////////////////////////////////////
  // RAM write and registered read
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= pixel_data;
    end
    // read data one cycle after address
    rd_data <= mem[rd_addr];
  end

  // strobe on the cycle the last pixel lands
  assign capture_done = wr_en && (wr_addr == last_addr);

endmodule

// ==== verilog/frame_ctrl.sv ====
`timescale 1ns/1ns

module frame_ctrl (
  input  logic clk,
  input  logic uart_reset,
  input  logic store,
  input  logic send,
  input  logic frame_start,
  input  logic capture_done,
  input  logic send_done,
  output logic capture_en,
  output logic send_start,
  output logic busy,
  output logic frame_ready
);

  frame_uart_pkg::ctrl_state_e state;
  frame_uart_pkg::ctrl_state_e state_nxt;

  ////////////////////////////////////////
  // phase register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (uart_reset) begin
      state <= frame_uart_pkg::ctrl_idle;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////
  // next phase
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      frame_uart_pkg::ctrl_idle: begin
        // nothing captured yet, send is ignored here
        if (store) begin
          state_nxt = frame_uart_pkg::ctrl_armed;
        end
      end
      frame_uart_pkg::ctrl_armed: begin
        // wait for the first frame start
        if (frame_start) begin
          state_nxt = frame_uart_pkg::ctrl_capture;
        end
      end
      frame_uart_pkg::ctrl_capture: begin
        // done strobe comes with the last write
        if (capture_done) begin
          state_nxt = frame_uart_pkg::ctrl_ready;
        end
      end
      frame_uart_pkg::ctrl_ready: begin
        // send wins over a new store
        if (send) begin
          state_nxt = frame_uart_pkg::ctrl_send;
        end else if (store) begin
          state_nxt = frame_uart_pkg::ctrl_armed;
        end
      end
      frame_uart_pkg::ctrl_send: begin
        // frame stays in RAM, can be resent
        if (send_done) begin
          state_nxt = frame_uart_pkg::ctrl_ready;
        end
      end
      default: begin
        state_nxt = frame_uart_pkg::ctrl_idle;
      end
    endcase
  end

  // decoded from the registered phase
  assign capture_en  = (state == frame_uart_pkg::ctrl_capture);
  assign frame_ready = (state == frame_uart_pkg::ctrl_ready);
  assign busy        = (state == frame_uart_pkg::ctrl_send);

  // one cycle kick, same cycle as the send strobe
  assign send_start  = (state == frame_uart_pkg::ctrl_ready) && send;

endmodule

// ==== verilog/frame_uart_pkg.sv ====
`include "frame_uart_cfg.svh"

package frame_uart_pkg;

  // payload types
  typedef logic [`PIXEL_W-1:0] pixel_t;
  typedef logic [`FRAME_ADDR_W-1:0] frame_addr_t;
  typedef logic [`UART_BYTE_W-1:0] uart_byte_t;

  // main controller phases
  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_armed,
    ctrl_capture,
    ctrl_ready,
    ctrl_send
  } ctrl_state_e;

  // byte order within a pixel, green first
  typedef enum logic [1:0] {
    color_green,
    color_blue,
    color_red
  } color_sel_e;

  // serial transmitter phases
  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_e;

endpackage

// ==== include/frame_uart_cfg.svh ====
`ifndef FRAME_UART_CFG_SVH
`define FRAME_UART_CFG_SVH

// pixels in one captured frame
`define FRAME_PIXELS 16
// address width for the frame RAM
`define FRAME_ADDR_W 4

// rgb332 pixel, 3 red, 3 green, 2 blue
`define PIXEL_W 8
// one serial byte
`define UART_BYTE_W 8

// clocks per serial bit
`define CLKS_PER_BIT 8

`endif
